//--- design/rnn_defines.svh
`ifndef RNN_DEFINES_SVH
`define RNN_DEFINES_SVH

// fixed-point format, Q16.16
`define FIXED_W 32
`define FRAC_W 16

// layer shape
`define NB_INPUTS 8
`define NB_NEURONS 4

// weight index is input*NB_NEURONS + neuron
`define W_ADDR_W 5

// tanh table covers |x| < 4.0 in steps of 1/256
`define TANH_ADDR_W 10
`define TANH_FRAC_W 8

`define ONE_Q 32'sd65536
`define HALF_Q 32'sd32768

// weights are stored scaled by 256
`define SCALE_SHIFT 8

`endif

//--- design/rnn_pkg.sv
`include "rnn_defines.svh"

package rnn_pkg;

	typedef logic signed [`FIXED_W-1:0] fixed_t;

	typedef enum logic [1:0] {
		ACT_TANH    = 2'd0,
		ACT_SIGMOID = 2'd1,
		ACT_RELU    = 2'd2
	} act_e;

	// which store a configuration word goes to
	typedef enum logic [1:0] {
		CFG_WEIGHT = 2'd0,
		CFG_BIAS   = 2'd1,
		CFG_TABLE  = 2'd2
	} cfg_sel_e;

	typedef enum logic [2:0] {
		IDLE  = 3'd0,
		LOAD  = 3'd1,
		ACCUM = 3'd2,
		DRAIN = 3'd3
	} eng_state_e;

endpackage

//--- design/coef_mem.sv
`timescale 1ns/1ps
`include "rnn_defines.svh"

module coef_mem
	import rnn_pkg::*;
(
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              cfg_wr_i,
	input  cfg_sel_e                          cfg_sel_i,
	input  logic [`TANH_ADDR_W-1:0]           cfg_addr_i,
	input  fixed_t                            cfg_data_i,
	input  logic [`W_ADDR_W-1:0]              w_addr_i,
	input  logic [$clog2(`NB_NEURONS)-1:0]    b_addr_i,
	output fixed_t                            w_data_o,
	output fixed_t                            b_data_o
);

	fixed_t weight_mem [0:`NB_INPUTS*`NB_NEURONS-1];
	fixed_t bias_mem [0:`NB_NEURONS-1];

	// host writes, only one store per strobe
	always_ff @(posedge clk) begin
		if (cfg_wr_i && cfg_sel_i == CFG_WEIGHT) begin
			weight_mem[cfg_addr_i[`W_ADDR_W-1:0]] <= cfg_data_i;
		end
		if (cfg_wr_i && cfg_sel_i == CFG_BIAS) begin
			bias_mem[cfg_addr_i[$clog2(`NB_NEURONS)-1:0]] <= cfg_data_i;
		end
	end

	// registered read, data one cycle after address
	always_ff @(posedge clk) begin
		if (rst) begin
			w_data_o <= '0;
			b_data_o <= '0;
		end else begin
			w_data_o <= weight_mem[w_addr_i];
			b_data_o <= bias_mem[b_addr_i];
		end
	end

endmodule

//--- design/feature_buf.sv
`timescale 1ns/1ps
`include "rnn_defines.svh"

module feature_buf
	import rnn_pkg::*;
(
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             feat_valid_i,
	output logic                             feat_ready_o,
	input  fixed_t                           feat_data_i,
	input  act_e                             act_i,
	input  logic                             frame_done_i,
	input  logic [$clog2(`NB_INPUTS)-1:0]    feat_idx_i,
	output fixed_t                           feat_o,
	output act_e                             act_o,
	output logic                             frame_full_o
);

	fixed_t feat_mem [0:`NB_INPUTS-1];
	logic [$clog2(`NB_INPUTS):0] wr_cnt;
	logic wr_en;

	assign frame_full_o = (wr_cnt == `NB_INPUTS);
	// frame is held until the engine has delivered every output
	assign feat_ready_o = !frame_full_o;
	assign wr_en = feat_valid_i && feat_ready_o;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_cnt <= '0;
			act_o <= ACT_TANH;
		end else if (frame_done_i) begin
			wr_cnt <= '0;
		end else if (wr_en) begin
			wr_cnt <= wr_cnt + 1'b1;
			// opcode rides with the first feature
			if (wr_cnt == '0) begin
				act_o <= act_i;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			feat_mem[wr_cnt[$clog2(`NB_INPUTS)-1:0]] <= feat_data_i;
		end
	end

	assign feat_o = feat_mem[feat_idx_i];

endmodule

//--- design/act_unit.sv
`timescale 1ns/1ps
`include "rnn_defines.svh"

module act_unit
	import rnn_pkg::*;
(
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       en_i,
	input  logic                       cfg_wr_i,
	input  cfg_sel_e                   cfg_sel_i,
	input  logic [`TANH_ADDR_W-1:0]    cfg_addr_i,
	input  fixed_t                     cfg_data_i,
	input  logic                       in_valid_i,
	input  fixed_t                     in_data_i,
	input  act_e                       in_act_i,
	output logic                       res_valid_o,
	output fixed_t                     res_data_o
);

	fixed_t tanh_mem [0:(1<<`TANH_ADDR_W)-1];

	fixed_t arg;
	fixed_t abs_v;
	logic [`TANH_ADDR_W-1:0] tab_idx;
	logic [`TANH_ADDR_W-1:0] tab_idx_nxt;

	logic s1_valid;
	fixed_t s1_lo;
	fixed_t s1_hi;
	logic [`TANH_FRAC_W-1:0] s1_frac;
	logic s1_neg;
	logic s1_oor;
	act_e s1_act;
	fixed_t s1_relu;

	logic signed [`TANH_FRAC_W+1:0] wt_lo;
	logic signed [`TANH_FRAC_W+1:0] wt_hi;
	logic signed [`FIXED_W+`TANH_FRAC_W+1:0] mix;
	logic signed [`FIXED_W+`TANH_FRAC_W+1:0] mix_sh;
	fixed_t mag;
	fixed_t tanh_v;
	fixed_t sig_v;
	fixed_t res_d;

	always_ff @(posedge clk) begin
		if (cfg_wr_i && cfg_sel_i == CFG_TABLE) begin
			tanh_mem[cfg_addr_i] <= cfg_data_i;
		end
	end

	// sigmoid(x) = (tanh(x/2) + 1) / 2
	assign arg = (in_act_i == ACT_SIGMOID) ? (in_data_i >>> 1) : in_data_i;
	assign abs_v = arg[`FIXED_W-1] ? -arg : arg;
	assign tab_idx = abs_v[`TANH_FRAC_W +: `TANH_ADDR_W];
	// last entry has no neighbour, reuse it
	assign tab_idx_nxt = (&tab_idx) ? tab_idx : tab_idx + 1'b1;

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
		end else if (en_i) begin
			s1_valid <= in_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (en_i) begin
			s1_lo <= tanh_mem[tab_idx];
			s1_hi <= tanh_mem[tab_idx_nxt];
			s1_frac <= abs_v[`TANH_FRAC_W-1:0];
			s1_neg <= arg[`FIXED_W-1];
			// |x| >= 4.0 is past the table
			s1_oor <= |abs_v[`FIXED_W-1:`TANH_FRAC_W+`TANH_ADDR_W];
			s1_act <= in_act_i;
			s1_relu <= in_data_i[`FIXED_W-1] ? '0 : in_data_i;
		end
	end

	// linear interpolation between neighbouring entries
	assign wt_hi = $signed({2'b00, s1_frac});
	assign wt_lo = $signed({2'b01, {`TANH_FRAC_W{1'b0}}}) - wt_hi;
	assign mix = s1_lo * wt_lo + s1_hi * wt_hi;
	assign mix_sh = mix >>> `TANH_FRAC_W;
	assign mag = s1_oor ? `ONE_Q : mix_sh[`FIXED_W-1:0];
	assign tanh_v = s1_neg ? -mag : mag;
	assign sig_v = (tanh_v >>> 1) + `HALF_Q;

	always_comb begin
		case (s1_act)
			ACT_SIGMOID: res_d = sig_v;
			ACT_RELU:    res_d = s1_relu;
			default:     res_d = tanh_v;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid_o <= 1'b0;
		end else if (en_i) begin
			res_valid_o <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (en_i) begin
			res_data_o <= res_d;
		end
	end

endmodule

//--- design/dense_engine.sv
`timescale 1ns/1ps
`include "rnn_defines.svh"

module dense_engine
	import rnn_pkg::*;
(
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             cfg_valid_i,
	output logic                             cfg_ready_o,
	output logic                             cfg_wr_o,
	input  logic                             frame_full_i,
	output logic                             frame_done_o,
	output logic [$clog2(`NB_INPUTS)-1:0]    feat_idx_o,
	input  fixed_t                           feat_i,
	input  act_e                             act_i,
	output logic [`W_ADDR_W-1:0]             w_addr_o,
	output logic [$clog2(`NB_NEURONS)-1:0]   b_addr_o,
	input  fixed_t                           w_data_i,
	input  fixed_t                           b_data_i,
	output logic                             act_en_o,
	output logic                             act_valid_o,
	output fixed_t                           act_data_o,
	output act_e                             act_sel_o,
	input  logic                             res_valid_i,
	input  fixed_t                           res_data_i,
	output logic                             out_valid_o,
	input  logic                             out_ready_i,
	output fixed_t                           out_data_o
);

	eng_state_e state;
	eng_state_e state_d;
	logic [$clog2(`NB_NEURONS)-1:0] neuron;
	logic [$clog2(`NB_NEURONS)-1:0] neuron_d;
	logic [$clog2(`NB_INPUTS)-1:0] idx;
	logic [$clog2(`NB_INPUTS)-1:0] idx_d;
	logic [$clog2(`NB_NEURONS)-1:0] out_cnt;
	logic issue_pend;
	logic issue;
	logic out_fire;
	logic last_in;
	logic last_neuron;

	fixed_t acc;
	logic signed [2*`FIXED_W-1:0] prod;
	fixed_t prod_q;

	// coefficients only change while no frame is being worked on
	assign cfg_ready_o = (state == IDLE) && !frame_full_i;
	assign cfg_wr_o = cfg_valid_i && cfg_ready_o;

	assign last_in = (int'(idx) == `NB_INPUTS - 1);
	assign last_neuron = (int'(neuron) == `NB_NEURONS - 1);

	// output stage is free, so the whole activation pipe may advance
	assign act_en_o = !out_valid_o || out_ready_i;
	assign act_valid_o = (state == DRAIN) && issue_pend;
	assign issue = act_valid_o && act_en_o;
	assign act_data_o = acc >>> `SCALE_SHIFT;
	assign act_sel_o = act_i;

	assign out_fire = out_valid_o && out_ready_i;
	assign frame_done_o = out_fire && (int'(out_cnt) == `NB_NEURONS - 1);

	always_comb begin
		state_d = state;
		neuron_d = neuron;
		idx_d = idx;
		case (state)
			IDLE: begin
				if (frame_full_i) begin
					state_d = LOAD;
				end
			end
			LOAD: begin
				state_d = ACCUM;
			end
			ACCUM: begin
				if (last_in) begin
					state_d = DRAIN;
				end else begin
					idx_d = idx + 1'b1;
				end
			end
			DRAIN: begin
				if (issue && !last_neuron) begin
					neuron_d = neuron + 1'b1;
					idx_d = '0;
					state_d = LOAD;
				end else if (frame_done_o) begin
					neuron_d = '0;
					idx_d = '0;
					state_d = IDLE;
				end
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	// addresses follow next-cycle counters so read data lines up
	assign w_addr_o = {idx_d, neuron_d};
	assign b_addr_o = neuron_d;
	assign feat_idx_o = idx;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			neuron <= '0;
			idx <= '0;
			issue_pend <= 1'b0;
			out_valid_o <= 1'b0;
			out_cnt <= '0;
		end else begin
			state <= state_d;
			neuron <= neuron_d;
			idx <= idx_d;
			if (state == ACCUM && last_in) begin
				issue_pend <= 1'b1;
			end else if (issue) begin
				issue_pend <= 1'b0;
			end
			if (act_en_o) begin
				out_valid_o <= res_valid_i;
			end
			if (frame_done_o) begin
				out_cnt <= '0;
			end else if (out_fire) begin
				out_cnt <= out_cnt + 1'b1;
			end
		end
	end

	// Q16.16 product, keep the middle 32 bits
	assign prod = w_data_i * feat_i;
	assign prod_q = prod[`FRAC_W +: `FIXED_W];

	always_ff @(posedge clk) begin
		if (state == LOAD) begin
			acc <= b_data_i;
		end else if (state == ACCUM) begin
			acc <= acc + prod_q;
		end
		if (act_en_o && res_valid_i) begin
			out_data_o <= res_data_i;
		end
	end

endmodule

//--- design/rnn_dense_top.sv
`timescale 1ns/1ps
`include "rnn_defines.svh"

module rnn_dense_top
	import rnn_pkg::*;
(
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       cfg_valid_i,
	output logic                       cfg_ready_o,
	input  cfg_sel_e                   cfg_sel_i,
	input  logic [`TANH_ADDR_W-1:0]    cfg_addr_i,
	input  fixed_t                     cfg_data_i,
	input  logic                       feat_valid_i,
	output logic                       feat_ready_o,
	input  fixed_t                     feat_data_i,
	input  act_e                       act_i,
	output logic                       out_valid_o,
	input  logic                       out_ready_i,
	output fixed_t                     out_data_o
);

	logic cfg_wr;
	logic frame_full;
	logic frame_done;
	logic [$clog2(`NB_INPUTS)-1:0] feat_idx;
	fixed_t feat;
	act_e frame_act;
	logic [`W_ADDR_W-1:0] w_addr;
	logic [$clog2(`NB_NEURONS)-1:0] b_addr;
	fixed_t w_data;
	fixed_t b_data;
	logic act_en;
	logic act_valid;
	fixed_t act_data;
	act_e act_sel;
	logic res_valid;
	fixed_t res_data;

	coef_mem i_coef_mem (
		.clk        (clk),
		.rst        (rst),
		.cfg_wr_i   (cfg_wr),
		.cfg_sel_i  (cfg_sel_i),
		.cfg_addr_i (cfg_addr_i),
		.cfg_data_i (cfg_data_i),
		.w_addr_i   (w_addr),
		.b_addr_i   (b_addr),
		.w_data_o   (w_data),
		.b_data_o   (b_data)
	);

	feature_buf i_feature_buf (
		.clk          (clk),
		.rst          (rst),
		.feat_valid_i (feat_valid_i),
		.feat_ready_o (feat_ready_o),
		.feat_data_i  (feat_data_i),
		.act_i        (act_i),
		.frame_done_i (frame_done),
		.feat_idx_i   (feat_idx),
		.feat_o       (feat),
		.act_o        (frame_act),
		.frame_full_o (frame_full)
	);

	act_unit i_act_unit (
		.clk         (clk),
		.rst         (rst),
		.en_i        (act_en),
		.cfg_wr_i    (cfg_wr),
		.cfg_sel_i   (cfg_sel_i),
		.cfg_addr_i  (cfg_addr_i),
		.cfg_data_i  (cfg_data_i),
		.in_valid_i  (act_valid),
		.in_data_i   (act_data),
		.in_act_i    (act_sel),
		.res_valid_o (res_valid),
		.res_data_o  (res_data)
	);

	dense_engine i_dense_engine (
		.clk          (clk),
		.rst          (rst),
		.cfg_valid_i  (cfg_valid_i),
		.cfg_ready_o  (cfg_ready_o),
		.cfg_wr_o     (cfg_wr),
		.frame_full_i (frame_full),
		.frame_done_o (frame_done),
		.feat_idx_o   (feat_idx),
		.feat_i       (feat),
		.act_i        (frame_act),
		.w_addr_o     (w_addr),
		.b_addr_o     (b_addr),
		.w_data_i     (w_data),
		.b_data_i     (b_data),
		.act_en_o     (act_en),
		.act_valid_o  (act_valid),
		.act_data_o   (act_data),
		.act_sel_o    (act_sel),
		.res_valid_i  (res_valid),
		.res_data_i   (res_data),
		.out_valid_o  (out_valid_o),
		.out_ready_i  (out_ready_i),
		.out_data_o   (out_data_o)
	);

endmodule

//--- tests/tb_rnn_dense.sv
`timescale 1ns/1ps
`include "rnn_defines.svh"

module tb_rnn_dense
	import rnn_pkg::*;
();

	// table ~1030, coefficient loads ~200, frames ~700 cycles
	localparam int TIMEOUT_CYCLES = 4000;
	localparam int NB_W = `NB_INPUTS * `NB_NEURONS;

	logic clk;
	logic rst;
	logic cfg_valid_i;
	logic cfg_ready_o;
	cfg_sel_e cfg_sel_i;
	logic [`TANH_ADDR_W-1:0] cfg_addr_i;
	fixed_t cfg_data_i;
	logic feat_valid_i;
	logic feat_ready_o;
	fixed_t feat_data_i;
	act_e act_i;
	logic out_valid_o;
	logic out_ready_i;
	fixed_t out_data_o;

	fixed_t w_mod [0:NB_W-1];
	fixed_t b_mod [0:`NB_NEURONS-1];
	fixed_t feat_v [0:`NB_INPUTS-1];
	fixed_t got [0:`NB_NEURONS-1];

	logic [31:0] rng_state;
	int cycle_cnt;
	int errors;
	int tests_run;
	int tests_failed;

	rnn_dense_top i_rnn_dense_top (
		.clk          (clk),
		.rst          (rst),
		.cfg_valid_i  (cfg_valid_i),
		.cfg_ready_o  (cfg_ready_o),
		.cfg_sel_i    (cfg_sel_i),
		.cfg_addr_i   (cfg_addr_i),
		.cfg_data_i   (cfg_data_i),
		.feat_valid_i (feat_valid_i),
		.feat_ready_o (feat_ready_o),
		.feat_data_i  (feat_data_i),
		.act_i        (act_i),
		.out_valid_o  (out_valid_o),
		.out_ready_i  (out_ready_i),
		.out_data_o   (out_data_o)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Testbench failed");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// ramp loaded into the tanh table
	function automatic int table_entry(input int k);
		return (k * 64 > 65536) ? 65536 : k * 64;
	endfunction

	function automatic fixed_t activate(input int x, input act_e act);
		int a;
		int m;
		int k;
		int k1;
		int f;
		int mag;
		int t;
		longint mix;
		if (act == ACT_RELU) begin
			return (x < 0) ? 0 : x;
		end
		// sigmoid looks up tanh at x/2
		a = (act == ACT_SIGMOID) ? (x >>> 1) : x;
		m = (a < 0) ? -a : a;
		if (m >= 262144) begin
			mag = 65536;
		end else begin
			k = m >>> 8;
			f = m & 255;
			k1 = (k == 1023) ? 1023 : k + 1;
			mix = longint'(table_entry(k)) * (256 - f) + longint'(table_entry(k1)) * f;
			mag = int'(mix >>> 8);
		end
		t = (a < 0) ? -mag : mag;
		if (act == ACT_SIGMOID) begin
			return (t >>> 1) + 32768;
		end
		return t;
	endfunction

	function automatic fixed_t expected_output(input int n, input act_e act);
		int acc;
		int i;
		longint p;
		acc = b_mod[n];
		for (i = 0; i < `NB_INPUTS; i++) begin
			p = longint'(w_mod[i * `NB_NEURONS + n]) * longint'(feat_v[i]);
			acc = acc + int'(p >>> 16);
		end
		return activate(acc >>> `SCALE_SHIFT, act);
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic check_value(input int n, input fixed_t value, input fixed_t exp);
		assert (value == exp) else begin
			$display("Error: out_data_o[%0d] got %h expected %h", n, value, exp);
			errors++;
		end
	endtask

	task automatic check_reset_state();
		assert (!out_valid_o) else begin
			$display("out_valid_o was high after reset");
			errors++;
		end
		assert (feat_ready_o) else begin
			$display("feat_ready_o was low after reset");
			errors++;
		end
		assert (cfg_ready_o) else begin
			$display("cfg_ready_o was low after reset");
			errors++;
		end
	endtask

	task automatic write_cfg(input cfg_sel_e sel, input int addr, input fixed_t data);
		logic done;
		cfg_valid_i = 1'b1;
		cfg_sel_i = sel;
		cfg_addr_i = addr[`TANH_ADDR_W-1:0];
		cfg_data_i = data;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			done = cfg_ready_o;
			next_cycle();
		end
		cfg_valid_i = 1'b0;
	endtask

	task automatic load_table();
		int k;
		for (k = 0; k < (1 << `TANH_ADDR_W); k++) begin
			write_cfg(CFG_TABLE, k, table_entry(k));
		end
	endtask

	task automatic write_coefs();
		int a;
		for (a = 0; a < NB_W; a++) begin
			write_cfg(CFG_WEIGHT, a, w_mod[a]);
		end
		for (a = 0; a < `NB_NEURONS; a++) begin
			write_cfg(CFG_BIAS, a, b_mod[a]);
		end
	endtask

	// weights within +-32.0, biases within +-64.0
	task automatic random_coefs();
		int a;
		logic [31:0] r;
		for (a = 0; a < NB_W; a++) begin
			r = next_rand();
			w_mod[a] = $signed(r & 32'h003F_FFFF) - 32'sh0020_0000;
		end
		for (a = 0; a < `NB_NEURONS; a++) begin
			r = next_rand();
			b_mod[a] = $signed(r & 32'h007F_FFFF) - 32'sh0040_0000;
		end
	endtask

	task automatic random_feats();
		int i;
		logic [31:0] r;
		for (i = 0; i < `NB_INPUTS; i++) begin
			r = next_rand();
			feat_v[i] = $signed(r & 32'h0003_FFFF) - 32'sh0002_0000;
		end
	endtask

	task automatic send_frame(input act_e act, input logic gaps);
		int i;
		int idle;
		logic done;
		for (i = 0; i < `NB_INPUTS; i++) begin
			if (gaps) begin
				idle = int'(next_rand() % 32'd3);
				repeat (idle) next_cycle();
			end
			feat_valid_i = 1'b1;
			feat_data_i = feat_v[i];
			act_i = act;
			done = 1'b0;
			while (!done) begin
				@(negedge clk);
				done = feat_ready_o;
				next_cycle();
			end
			feat_valid_i = 1'b0;
		end
	endtask

	task automatic collect_frame(input logic rand_ready, input logic watch_cfg);
		int n;
		logic stalled;
		logic [31:0] r;
		fixed_t held;
		n = 0;
		stalled = 1'b0;
		held = '0;
		r = next_rand();
		out_ready_i = rand_ready ? r[0] : 1'b1;
		while (n < `NB_NEURONS) begin
			@(negedge clk);
			if (watch_cfg) begin
				assert (!cfg_ready_o) else begin
					$display("cfg_ready_o was high while a frame was still in progress");
					errors++;
				end
			end
			// buffered frame stays locked until the last output leaves
			assert (!feat_ready_o) else begin
				$display("feat_ready_o was high while a frame was still in progress");
				errors++;
			end
			if (stalled) begin
				assert (out_valid_o) else begin
					$display("out_valid_o dropped before the stalled output was taken");
					errors++;
				end
				assert (out_data_o == held) else begin
					$display("Error: out_data_o changed while stalled, %h to %h", held, out_data_o);
					errors++;
				end
			end
			if (out_valid_o && out_ready_i) begin
				got[n] = out_data_o;
				n++;
			end
			stalled = out_valid_o && !out_ready_i;
			held = out_data_o;
			next_cycle();
			r = next_rand();
			out_ready_i = rand_ready ? r[0] : 1'b1;
		end
		out_ready_i = 1'b1;
		@(negedge clk);
		assert (!out_valid_o) else begin
			$display("an extra output appeared after the last neuron");
			errors++;
		end
		assert (feat_ready_o) else begin
			$display("feat_ready_o stayed low after the last output transfer");
			errors++;
		end
		if (watch_cfg) begin
			assert (cfg_ready_o) else begin
				$display("cfg_ready_o stayed low after the last output transfer");
				errors++;
			end
		end
		next_cycle();
	endtask

	task automatic check_frame(input act_e act);
		int n;
		for (n = 0; n < `NB_NEURONS; n++) begin
			check_value(n, got[n], expected_output(n, act));
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, errors - errs_before);
		end
	endtask

	task automatic test_tanh();
		int e0;
		e0 = errors;
		random_coefs();
		write_coefs();
		random_feats();
		send_frame(ACT_TANH, 1'b0);
		collect_frame(1'b0, 1'b0);
		check_frame(ACT_TANH);
		report_test("tanh frame", e0);
	endtask

	task automatic test_sigmoid();
		int e0;
		int n;
		e0 = errors;
		random_feats();
		send_frame(ACT_SIGMOID, 1'b0);
		collect_frame(1'b0, 1'b0);
		check_frame(ACT_SIGMOID);
		for (n = 0; n < `NB_NEURONS; n++) begin
			assert (got[n] >= 0 && got[n] <= `ONE_Q) else begin
				$display("sigmoid output %0d is outside the range 0 to one", n);
				errors++;
			end
		end
		report_test("sigmoid frame", e0);
	endtask

	task automatic test_relu();
		int e0;
		int n;
		e0 = errors;
		// even neurons pushed far negative, odd ones far positive
		for (n = 0; n < `NB_NEURONS; n++) begin
			b_mod[n] = (n % 2 == 0) ? -32'sd131072000 : 32'sd131072000;
			write_cfg(CFG_BIAS, n, b_mod[n]);
		end
		random_feats();
		send_frame(ACT_RELU, 1'b0);
		collect_frame(1'b0, 1'b0);
		for (n = 0; n < `NB_NEURONS; n++) begin
			if (n % 2 == 0) begin
				check_value(n, got[n], '0);
			end else begin
				check_value(n, got[n], expected_output(n, ACT_RELU));
			end
		end
		report_test("relu frame", e0);
	endtask

	task automatic test_saturation();
		int e0;
		int i;
		int n;
		logic [31:0] r;
		e0 = errors;
		// +-400.0 weights with features in [1,2) give |x| of 12.5 or more
		for (i = 0; i < `NB_INPUTS; i++) begin
			for (n = 0; n < `NB_NEURONS; n++) begin
				w_mod[i * `NB_NEURONS + n] = (n < 2) ? 32'sd26214400 : -32'sd26214400;
			end
			r = next_rand();
			feat_v[i] = $signed(32'h0001_0000 | (r & 32'h0000_FFFF));
		end
		for (n = 0; n < `NB_NEURONS; n++) begin
			b_mod[n] = '0;
		end
		write_coefs();
		send_frame(ACT_TANH, 1'b0);
		collect_frame(1'b0, 1'b0);
		for (n = 0; n < `NB_NEURONS; n++) begin
			check_value(n, got[n], (n < 2) ? `ONE_Q : -`ONE_Q);
		end
		check_frame(ACT_TANH);
		send_frame(ACT_SIGMOID, 1'b0);
		collect_frame(1'b0, 1'b0);
		for (n = 0; n < `NB_NEURONS; n++) begin
			check_value(n, got[n], (n < 2) ? `ONE_Q : '0);
		end
		check_frame(ACT_SIGMOID);
		report_test("saturation", e0);
	endtask

	task automatic test_backpressure();
		int e0;
		e0 = errors;
		random_coefs();
		write_coefs();
		random_feats();
		send_frame(ACT_TANH, 1'b1);
		collect_frame(1'b1, 1'b0);
		check_frame(ACT_TANH);
		random_feats();
		send_frame(ACT_SIGMOID, 1'b1);
		collect_frame(1'b1, 1'b0);
		check_frame(ACT_SIGMOID);
		report_test("back-pressure and gaps", e0);
	endtask

	task automatic test_cfg_gating();
		int e0;
		e0 = errors;
		random_feats();
		send_frame(ACT_TANH, 1'b0);
		collect_frame(1'b0, 1'b1);
		check_frame(ACT_TANH);
		// new bias for neuron 0 moves its input by 1/16
		b_mod[0] = b_mod[0] + 32'sh0010_0000;
		write_cfg(CFG_BIAS, 0, b_mod[0]);
		send_frame(ACT_TANH, 1'b0);
		collect_frame(1'b0, 1'b0);
		check_frame(ACT_TANH);
		report_test("configuration gating", e0);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		cfg_valid_i = 1'b0;
		cfg_sel_i = CFG_WEIGHT;
		cfg_addr_i = '0;
		cfg_data_i = '0;
		feat_valid_i = 1'b0;
		feat_data_i = '0;
		act_i = ACT_TANH;
		out_ready_i = 1'b1;
		rng_state = 32'd59538;
		cycle_cnt = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;

		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		check_reset_state();

		load_table();
		test_tanh();
		test_sigmoid();
		test_relu();
		test_saturation();
		test_backpressure();
		test_cfg_gating();

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+design
design/rnn_pkg.sv
design/coef_mem.sv
design/feature_buf.sv
design/act_unit.sv
design/dense_engine.sv
design/rnn_dense_top.sv
tests/tb_rnn_dense.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the dense layer testbench, then check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/1ps \
	--top-module tb_rnn_dense -f verilog.f > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/Vtb_rnn_dense > sim.log 2>&1
grep -q "^Testbench passed$" sim.log && echo "PASS" \
	|| { echo "FAIL, see sim.log"; exit 1; }
